// ==== source/SpiPkg.sv ====
package SpiPkg;

//----------------------------------------------------------
// Bus geometry and block decode
//----------------------------------------------------------
localparam int AdrsBits = 16;		// Internal bus address width
localparam logic [7:0] BlockBase = 8'h03;	// Upper address byte of this block

//----------------------------------------------------------
// Register map, low address byte
//----------------------------------------------------------
localparam logic [7:0] RegCtrl = 8'h00;	// en / cs
localparam logic [7:0] RegDiv = 8'h01;		// SCK half period divider
localparam logic [7:0] RegTxData = 8'h02;	// Write starts a transfer
localparam logic [7:0] RegRxData = 8'h03;	// Last received byte
localparam logic [7:0] RegStatus = 8'h04;	// busy / rxValid

localparam int DivBits = 16;		// Divider register width

//----------------------------------------------------------
// Bus and configuration bundles
//----------------------------------------------------------
// One access on the internal register bus
typedef struct packed {
	logic [AdrsBits-1:0] adrs;	// Block byte + register offset
	logic [31:0] wd;			// Write data
	logic wEn;					// Write strobe, one cycle
	logic rEn;					// Read strobe, one cycle
} busReqT;

// Read response, one cycle after rEn
typedef struct packed {
	logic [31:0] rd;			// Read data
	logic rVd;					// Read data valid
} busRspT;

// Static setup handed to the byte engine
typedef struct packed {
	logic en;					// Engine enable
	logic cs;					// Chip select asserted
	logic [DivBits-1:0] div;	// Half period = div+1 cycles
} spiCfgT;

// Master side SPI outputs
typedef struct packed {
	logic sck;
	logic mosi;
	logic csN;					// Active low chip select
} spiPinsT;

endpackage

// ==== source/SpiCsr.sv ====
module SpiCsr (
	input  logic sysClk,
	input  logic rstN,
	// Internal bus
	input  SpiPkg::busReqT busReq,
	output SpiPkg::busRspT busRsp,
	// To byte engine
	output SpiPkg::spiCfgT cfg,
	output logic start,			// One cycle transfer request
	output logic [7:0] txByte,	// Valid with start
	// From byte engine
	input  logic busy,
	input  logic done,			// One cycle, rxByte valid
	input  logic [7:0] rxByte
);

//----------------------------------------------------------
// Address decode
//----------------------------------------------------------
logic blockHit;
logic [7:0] offset;
logic wrHit;
logic rdHit;

assign blockHit = (busReq.adrs[SpiPkg::AdrsBits-1 -: 8] == SpiPkg::BlockBase);
assign offset = busReq.adrs[7:0];	// Register offset
assign wrHit = busReq.wEn && blockHit;
assign rdHit = busReq.rEn && blockHit;

//----------------------------------------------------------
// Register state
//----------------------------------------------------------
logic enQ;
logic csQ;
logic [SpiPkg::DivBits-1:0] divQ;
logic [7:0] rxDataQ;		// Byte from the last transfer
logic rxValidQ;				// Set on done, cleared by RegRxData read
logic [31:0] rdMux;
SpiPkg::busRspT rspQ;

// Configuration goes straight out to the engine
assign cfg.en = enQ;
assign cfg.cs = csQ;
assign cfg.div = divQ;

// Start only when enabled and idle, otherwise the write is dropped
assign start = wrHit && (offset == SpiPkg::RegTxData) && enQ && !busy;
assign txByte = busReq.wd[7:0];

// Read data select
always_comb
begin
	rdMux = '0;
	case (offset)
		SpiPkg::RegCtrl:   rdMux[1:0] = {csQ, enQ};
		SpiPkg::RegDiv:    rdMux[SpiPkg::DivBits-1:0] = divQ;
		SpiPkg::RegRxData: rdMux[7:0] = rxDataQ;
		SpiPkg::RegStatus: rdMux[1:0] = {rxValidQ, busy};
		default:           rdMux = '0;	// TxData is write only
	endcase
end

always_ff @(posedge sysClk)
begin
	if (!rstN)
	begin
		enQ      <= 1'b0;
		csQ      <= 1'b0;
		divQ     <= '0;
		rxDataQ  <= '0;
		rxValidQ <= 1'b0;
		rspQ     <= '0;
	end
	else
	begin
		// Control and divider writes
		if (wrHit && (offset == SpiPkg::RegCtrl))
		begin
			enQ <= busReq.wd[0];
			csQ <= busReq.wd[1];
		end
		if (wrHit && (offset == SpiPkg::RegDiv))
			divQ <= busReq.wd[SpiPkg::DivBits-1:0];

		// New data wins over a clearing read in the same cycle
		if (done)
		begin
			rxDataQ  <= rxByte;
			rxValidQ <= 1'b1;
		end
		else if (rdHit && (offset == SpiPkg::RegRxData))
			rxValidQ <= 1'b0;

		// Response one cycle after the strobe
		rspQ.rVd <= rdHit;
		rspQ.rd  <= rdHit ? rdMux : '0;	// Outside the block reads zero
	end
end

assign busRsp = rspQ;

endmodule

// ==== source/SpiByteEngine.sv ====
module SpiByteEngine (
	input  logic sysClk,
	input  logic rstN,
	// From register bank
	input  SpiPkg::spiCfgT cfg,
	input  logic start,			// One cycle request
	input  logic [7:0] txByte,	// Byte to send, sampled with start
	// Status back to register bank
	output logic busy,			// High for the whole transfer
	output logic done,			// One cycle pulse at the end
	output logic [7:0] rxByte,	// Valid with done
	// SPI pins
	output SpiPkg::spiPinsT pins,
	input  logic miso
);

//----------------------------------------------------------
// Half period pacing
//----------------------------------------------------------
logic [SpiPkg::DivBits-1:0] halfLen;	// Last divCnt value of a half period
logic [SpiPkg::DivBits-1:0] divCnt;
logic [3:0] halfCnt;				// 16 half periods per byte
logic halfEnd;
logic lastHalf;

// A zero divider behaves as one, so OR in a 1 when div is zero
assign halfLen = cfg.div | {{(SpiPkg::DivBits-1){1'b0}}, (cfg.div == '0)};

//----------------------------------------------------------
// Shift state
//----------------------------------------------------------
logic [7:0] shiftReg;		// MOSI out of bit 7, MISO into bit 0
logic misoSmp;				// MISO held from rising edge to falling edge
logic sckQ;
logic busyQ;
logic doneQ;

assign halfEnd = busyQ && (divCnt == halfLen);
assign lastHalf = (halfCnt == 4'd15);

always_ff @(posedge sysClk)
begin
	if (!rstN)
	begin
		divCnt   <= '0;
		halfCnt  <= '0;
		shiftReg <= '0;
		misoSmp  <= 1'b0;
		sckQ     <= 1'b0;
		busyQ    <= 1'b0;
		doneQ    <= 1'b0;
	end
	else
	begin
		doneQ <= 1'b0;	// Pulse by default low

		if (!busyQ)
		begin
			// Idle, wait for an accepted start
			if (start && cfg.en)
			begin
				busyQ    <= 1'b1;
				shiftReg <= txByte;	// First MOSI bit shows next cycle
				divCnt   <= '0;
				halfCnt  <= '0;
			end
		end
		else if (halfEnd)
		begin
			divCnt  <= '0;
			halfCnt <= halfCnt + 4'd1;
			sckQ    <= ~sckQ;

			if (!sckQ)
				misoSmp <= miso;	// Rising SCK edge samples
			else
				shiftReg <= {shiftReg[6:0], misoSmp};	// Falling edge shifts

			// End of the 16th half period
			if (lastHalf)
			begin
				busyQ <= 1'b0;
				doneQ <= 1'b1;
			end
		end
		else
			divCnt <= divCnt + 1'b1;
	end
end

//----------------------------------------------------------
// Outputs
//----------------------------------------------------------
assign busy = busyQ;
assign done = doneQ;
assign rxByte = shiftReg;	// Eight shifts leave the received byte

assign pins.sck = sckQ;
assign pins.mosi = shiftReg[7];
assign pins.csN = ~cfg.cs;	// Software owned, not tied to transfers

endmodule

// ==== source/SpiBlock.sv ====
module SpiBlock (
	input  logic sysClk,
	input  logic rstN,
	// Internal register bus
	input  SpiPkg::busReqT busReq,
	output SpiPkg::busRspT busRsp,
	// SPI master pins
	output SpiPkg::spiPinsT spiPins,
	input  logic miso,
	// Transfer complete pulse
	output logic spiIntr
);

//----------------------------------------------------------
// Register bank to engine wiring
//----------------------------------------------------------
SpiPkg::spiCfgT cfg;
logic start;
logic [7:0] txByte;
logic busy;
logic [7:0] rxByte;

SpiCsr csr0 (
	.sysClk (sysClk),
	.rstN   (rstN),
	.busReq (busReq),
	.busRsp (busRsp),
	.cfg    (cfg),
	.start  (start),
	.txByte (txByte),
	.busy   (busy),
	.done   (spiIntr),	// done doubles as the interrupt
	.rxByte (rxByte)
);

SpiByteEngine engine0 (
	.sysClk (sysClk),
	.rstN   (rstN),
	.cfg    (cfg),
	.start  (start),
	.txByte (txByte),
	.busy   (busy),
	.done   (spiIntr),
	.rxByte (rxByte),
	.pins   (spiPins),
	.miso   (miso)
);

endmodule

// ==== verification/SpiSlaveModel.sv ====
module SpiSlaveModel (
	input  SpiPkg::spiPinsT pins,
	input  logic [7:0] preset,		// Byte returned to the master
	output logic miso,
	output logic [7:0] captured,	// Last eight MOSI bits
	output int riseCnt				// Every rising SCK edge, selected or not
);

timeunit 1ns;
timeprecision 100ps;

//------------------------------------------------------------
// Mode 0 slave, MSB first
//------------------------------------------------------------
logic [7:0] capQ = 8'h00;
int riseQ = 0;
int fallQ = 0;			// Falling edges while selected
logic [2:0] bitIdx;

// Eight falling edges per byte, so the low count bits index the bit
assign bitIdx = 3'd7 - fallQ[2:0];
assign miso = preset[bitIdx];

// MOSI is stable across the rising edge
always @(posedge pins.sck)
begin
	riseQ <= riseQ + 1;
	if (!pins.csN)
		capQ <= {capQ[6:0], pins.mosi};	// Shift in at the bottom
end

// Next MISO bit after each falling edge
always @(negedge pins.sck)
begin
	if (!pins.csN)
		fallQ <= fallQ + 1;
end

assign captured = capQ;
assign riseCnt = riseQ;

endmodule

// ==== verification/SpiBlockTb.sv ====
module SpiBlockTb;

timeunit 1ns;
timeprecision 100ps;

localparam int NumXfer = 6;		// Random transfers

logic sysClk;
logic rstN;
SpiPkg::busReqT req;
SpiPkg::busRspT busRsp;
SpiPkg::spiPinsT spiPins;
logic miso;
logic spiIntr;
logic [7:0] slavePreset;
logic [7:0] slaveCapt;
int slaveRises;

int errors = 0;
int cycleNum = 0;		// Rising clock edges so far
int intrCnt = 0;		// Cycles with spiIntr high
int budget = 0;			// Watchdog limit in cycles, zero until known

SpiBlock dut0 (
	.sysClk  (sysClk),
	.rstN    (rstN),
	.busReq  (req),
	.busRsp  (busRsp),
	.spiPins (spiPins),
	.miso    (miso),
	.spiIntr (spiIntr)
);

SpiSlaveModel slave0 (
	.pins     (spiPins),
	.preset   (slavePreset),
	.miso     (miso),
	.captured (slaveCapt),
	.riseCnt  (slaveRises)
);

initial
begin
	sysClk = 1'b0;
	forever #2 sysClk = ~sysClk;	// 4 ns period
end

always @(posedge sysClk)
	cycleNum <= cycleNum + 1;

// Interrupt sampled mid cycle
always @(negedge sysClk)
	if (spiIntr)
		intrCnt <= intrCnt + 1;

// SCK half period in clock cycles, zero divider counts as one
function automatic int halfPeriod(input logic [15:0] d);
	return (d == 16'd0) ? 2 : int'(d) + 1;
endfunction

//------------------------------------------------------------
// Compare tasks
//------------------------------------------------------------
task automatic checkRsp(input string name, input SpiPkg::busRspT exp, input SpiPkg::busRspT act);
	if (act !== exp)
	begin
		$display("** Error %s expected %h actual %h", name, exp, act);
		errors++;
	end
endtask

task automatic checkByte(input string name, input logic [7:0] exp, input logic [7:0] act);
	if (act !== exp)
	begin
		$display("** Error %s expected %h actual %h", name, exp, act);
		errors++;
	end
endtask

// MOSI left out, it has no defined idle value
task automatic checkPins(input string name, input SpiPkg::spiPinsT exp, input SpiPkg::spiPinsT act);
	if (act.sck !== exp.sck || act.csN !== exp.csN)
	begin
		$display("** Error %s expected %h actual %h", name, exp, act);
		errors++;
	end
endtask

task automatic checkCount(input string name, input int exp, input int act);
	if (act != exp)
	begin
		$display("** Error %s expected %h actual %h", name, exp, act);
		errors++;
	end
endtask

//------------------------------------------------------------
// Bus tasks, entered and left on a falling edge
//------------------------------------------------------------
task automatic busWrite(input logic [7:0] blk, input logic [7:0] off, input logic [31:0] data);
	req.adrs = {blk, off};
	req.wd = data;
	req.wEn = 1'b1;
	@(negedge sysClk);
	req.wEn = 1'b0;
	req.wd = '0;
endtask

task automatic busRead(input logic [7:0] off, output SpiPkg::busRspT rsp);
	int waitCnt;
	req.adrs = {SpiPkg::BlockBase, off};
	req.rEn = 1'b1;
	@(negedge sysClk);
	req.rEn = 1'b0;
	waitCnt = 1;
	while (!busRsp.rVd && waitCnt < 2)
	begin
		@(negedge sysClk);
		waitCnt++;
	end
	if (!busRsp.rVd)
	begin
		$display("Read of offset %h got no response within two cycles", off);
		errors++;
	end
	rsp = busRsp;
endtask

task automatic checkReg(input string name, input logic [7:0] off, input logic [31:0] val);
	SpiPkg::busRspT rsp;
	SpiPkg::busRspT exp;
	busRead(off, rsp);
	exp.rd = val;
	exp.rVd = 1'b1;
	checkRsp(name, exp, rsp);
endtask

// Wait for the interrupt pulse, give up well past the expected time
task automatic waitIntr(input int limit);
	int startCycle;
	startCycle = cycleNum;
	while (!spiIntr && (cycleNum - startCycle) < limit)
		@(negedge sysClk);
	if (!spiIntr)
	begin
		$display("spiIntr never pulsed, transfer did not complete");
		errors++;
	end
endtask

//------------------------------------------------------------
// Directed tests
//------------------------------------------------------------
task automatic testReset();
	SpiPkg::spiPinsT expPins;
	expPins.sck = 1'b0;
	expPins.mosi = 1'b0;
	expPins.csN = 1'b1;			// Deselected out of reset
	checkPins("spiPins", expPins, spiPins);
	checkReg("RegCtrl", SpiPkg::RegCtrl, 32'h0);
	checkReg("RegDiv", SpiPkg::RegDiv, 32'h0);
	checkReg("RegTxData", SpiPkg::RegTxData, 32'h0);
	checkReg("RegRxData", SpiPkg::RegRxData, 32'h0);
	checkReg("RegStatus", SpiPkg::RegStatus, 32'h0);
	checkCount("spiIntr pulses", 0, intrCnt);
endtask

task automatic testRegs();
	SpiPkg::spiPinsT expPins;
	expPins.sck = 1'b0;
	expPins.mosi = 1'b0;
	busWrite(SpiPkg::BlockBase, SpiPkg::RegCtrl, 32'hFFFF_FFFF);
	checkReg("RegCtrl", SpiPkg::RegCtrl, 32'h3);	// en + cs only
	busWrite(SpiPkg::BlockBase, SpiPkg::RegDiv, 32'hABCD_1234);
	checkReg("RegDiv", SpiPkg::RegDiv, 32'h0000_1234);
	busWrite(SpiPkg::BlockBase, SpiPkg::RegCtrl, 32'h2);
	expPins.csN = 1'b0;
	checkPins("spiPins cs set", expPins, spiPins);
	busWrite(SpiPkg::BlockBase, SpiPkg::RegCtrl, 32'h0);
	expPins.csN = 1'b1;
	checkPins("spiPins cs clear", expPins, spiPins);
	// Other block address must not hit
	busWrite(SpiPkg::BlockBase ^ 8'h01, SpiPkg::RegCtrl, 32'h3);
	busWrite(SpiPkg::BlockBase ^ 8'h01, SpiPkg::RegDiv, 32'h5555);
	checkReg("RegCtrl foreign", SpiPkg::RegCtrl, 32'h0);
	checkReg("RegDiv foreign", SpiPkg::RegDiv, 32'h0000_1234);
	checkPins("spiPins foreign", expPins, spiPins);
endtask

task automatic runTransfer(input logic [7:0] txVal, input logic [7:0] rxVal, input logic [15:0] divVal);
	int expDelay;
	int startCycle;
	expDelay = 16 * halfPeriod(divVal) + 1;
	slavePreset = rxVal;
	busWrite(SpiPkg::BlockBase, SpiPkg::RegDiv, {16'h0, divVal});
	busWrite(SpiPkg::BlockBase, SpiPkg::RegCtrl, 32'h3);
	startCycle = cycleNum;		// Write cycle counts as the first
	busWrite(SpiPkg::BlockBase, SpiPkg::RegTxData, {24'h0, txVal});
	checkReg("RegStatus busy", SpiPkg::RegStatus, 32'h1);
	waitIntr(expDelay + 8);
	checkCount("spiIntr delay", expDelay, cycleNum - startCycle);
	@(negedge sysClk);
	if (spiIntr)
	begin
		$display("spiIntr stayed high for more than one cycle");
		errors++;
	end
	checkByte("slave MOSI byte", txVal, slaveCapt);
	checkReg("RegStatus rxValid", SpiPkg::RegStatus, 32'h2);
	checkReg("RegRxData", SpiPkg::RegRxData, {24'h0, rxVal});
	checkReg("RegStatus cleared", SpiPkg::RegStatus, 32'h0);
	busWrite(SpiPkg::BlockBase, SpiPkg::RegCtrl, 32'h1);	// Drop chip select
endtask

task automatic testIgnored(input logic [7:0] txA, input logic [7:0] txB, input logic [15:0] divVal);
	int rises;
	int intrs;
	rises = slaveRises;
	intrs = intrCnt;
	// Enable clear, cs set
	busWrite(SpiPkg::BlockBase, SpiPkg::RegDiv, 32'h1);
	busWrite(SpiPkg::BlockBase, SpiPkg::RegCtrl, 32'h2);
	busWrite(SpiPkg::BlockBase, SpiPkg::RegTxData, 32'hA5);
	repeat (16 * halfPeriod(16'd1) + 4) @(negedge sysClk);	// Past a full transfer
	checkCount("SCK rising edges", rises, slaveRises);
	checkCount("spiIntr pulses", intrs, intrCnt);
	checkReg("RegStatus idle", SpiPkg::RegStatus, 32'h0);
	// Second write lands while busy
	slavePreset = ~txA;
	busWrite(SpiPkg::BlockBase, SpiPkg::RegDiv, {16'h0, divVal});
	busWrite(SpiPkg::BlockBase, SpiPkg::RegCtrl, 32'h3);
	busWrite(SpiPkg::BlockBase, SpiPkg::RegTxData, {24'h0, txA});
	busWrite(SpiPkg::BlockBase, SpiPkg::RegTxData, {24'h0, txB});
	waitIntr(16 * halfPeriod(divVal) + 8);
	@(negedge sysClk);
	checkByte("slave MOSI byte busy", txA, slaveCapt);
	checkReg("RegRxData busy", SpiPkg::RegRxData, {24'h0, ~txA});
	busWrite(SpiPkg::BlockBase, SpiPkg::RegCtrl, 32'h0);
endtask

//------------------------------------------------------------
// Main sequence and watchdog
//------------------------------------------------------------
initial
begin
	logic [7:0] txList [NumXfer+1];
	logic [7:0] rxList [NumXfer+1];
	logic [15:0] divList [NumXfer+1];	// Last entry for the busy test
	int total;
	rstN = 1'b0;
	req = '0;
	slavePreset = 8'h00;
	void'($urandom(24));
	total = 0;
	for (int i = 0; i <= NumXfer; i++)
	begin
		txList[i] = 8'($urandom);
		rxList[i] = 8'($urandom);
		divList[i] = (i == 0) ? 16'd0 : 16'($urandom % 6);	// Zero divider first
		total += 16 * halfPeriod(divList[i]) + 20;
	end
	budget = total + 200;
	repeat (8) @(negedge sysClk);
	rstN = 1'b1;
	testReset();
	testRegs();
	for (int i = 0; i < NumXfer; i++)
		runTransfer(txList[i], rxList[i], divList[i]);
	testIgnored(txList[NumXfer], rxList[NumXfer], divList[NumXfer]);
	$display("Checks done, %0d errors", errors);
	if (errors == 0)
		$display(">>> PASS");
	else
		$display(">>> FAIL");
	$finish;
end

initial
begin
	wait (budget > 0);
	repeat (budget) @(posedge sysClk);
	$display("Watchdog timeout after %0d cycles, the tests did not finish", budget);
	$display(">>> FAIL");
	$finish;
end

endmodule

// ==== vlog.f ====
source/SpiPkg.sv
source/SpiCsr.sv
source/SpiByteEngine.sv
source/SpiBlock.sv
verification/SpiSlaveModel.sv
verification/SpiBlockTb.sv

// ==== Makefile ====
# Verilator build and run for the SPI block testbench
VERILATOR ?= verilator
TOP ?= SpiBlockTb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS ?= --binary --timing --timescale $(TIMESCALE)
SIM ?= $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# Build the simulation executable
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Run and fail unless the pass line shows up in the output
run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf $(BUILD_DIR)
